/* dv/eeprom_stimulus.txt */
# name op addr(hex) data(hex) ack_enable exp_rd_data(hex) exp_nack
# op W write, R read, B write with a wr strobe to ~addr/~data while busy
wr_basic        W 012 a5 1 00 0
rd_basic        R 012 00 1 a5 0
wr_blk0         W 034 11 1 00 0
wr_blk3         W 334 33 1 00 0
wr_blk7         W 734 77 1 00 0
rd_blk0         R 034 00 1 11 0
rd_blk3         R 334 00 1 33 0
rd_blk7         R 734 00 1 77 0
wr_noack        W 012 5a 0 00 1
rd_noack        R 012 00 0 00 1
rd_after_noack  R 012 00 1 a5 0
wr_before_busy  W 4cb 3c 1 00 0
wr_busy         B 334 96 1 00 0
rd_busy_ignored R 4cb 00 1 3c 0
rd_busy_taken   R 334 00 1 96 0
wr_top          W 7ff c7 1 00 0
rd_top          R 7ff 00 1 c7 0
rd_blk7_again   R 734 00 1 77 0

/* filelist.f */
+incdir+source
source/eeprom_pkg.sv
source/i2c_bit_engine.sv
source/eeprom_sequencer.sv
source/eeprom_ctrl_top.sv
dv/eeprom_slave_model.sv
dv/eeprom_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the EEPROM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module eeprom_tb -f filelist.f -o eeprom_sim
then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/eeprom_sim > sim.log 2>&1
then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q -x ">>> PASS" sim.log
then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* dv/eeprom_tb.sv */
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_tb;

    localparam int ACK_TIMEOUT = 2000;
    localparam int NAME_W = 8 * 24;

    logic                      CLK;
    logic                      RESET;
    logic                      wr;
    logic                      rd;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [`EEPROM_DATA_W-1:0] wr_data;
    logic                      ack;
    eeprom_pkg::eeprom_rsp_t   rsp;
    logic                      scl;
    logic                      sda_oe;
    logic                      slave_pull;
    logic                      ack_enable;
    wire                       sda;

    int pass_count = 0;
    int fail_count = 0;
    int test_errors = 0;
    int ack_total = 0;

    assign sda = ~(sda_oe | slave_pull);   // wired AND with pull-up

    eeprom_ctrl_top dut
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .sda_in  (sda),
        .ack     (ack),
        .rsp     (rsp),
        .scl     (scl),
        .sda_oe  (sda_oe)
    );

    eeprom_slave_model slave
    (
        .CLK        (CLK),
        .scl        (scl),
        .sda        (sda),
        .ack_enable (ack_enable),
        .sda_pull   (slave_pull)
    );

    always #10 CLK = ~CLK;

    always @(negedge CLK)
    begin
        if (ack)
            ack_total <= ack_total + 1;
    end

    task automatic check_rsp_data(input logic [NAME_W-1:0] name,
                                  input logic [`EEPROM_DATA_W-1:0] expected,
                                  input logic [`EEPROM_DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %0s read data expected 0x%02h actual 0x%02h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_nack(input logic [NAME_W-1:0] name, input logic expected,
                              input eeprom_pkg::eeprom_rsp_t actual);
        if (actual.nack !== expected)
        begin
            $display("[ERROR] %0s nack expected %0b actual %0b", name, expected, actual.nack);
            test_errors++;
        end
    endtask

    task automatic check_line(input logic [NAME_W-1:0] name, input logic [8*8-1:0] label,
                              input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %0s %0s expected %0b actual %0b", name, label, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_test(input logic [NAME_W-1:0] name);
        if (test_errors == 0)
        begin
            pass_count++;
            $display("%0s passed", name);
        end
        else
        begin
            fail_count++;
            $display("%0s failed with %0d errors", name, test_errors);
        end
    endtask

    task automatic drive_strobe(input logic is_wr, input logic [`EEPROM_ADDR_W-1:0] a,
                                input logic [`EEPROM_DATA_W-1:0] d);
        @(negedge CLK);
        wr      = is_wr;
        rd      = !is_wr;
        addr    = a;
        wr_data = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack(output logic seen, output eeprom_pkg::eeprom_rsp_t got);
        int cycles;
        seen   = 1'b0;
        got    = '0;
        cycles = 0;
        while (!seen && cycles < ACK_TIMEOUT)
        begin
            @(negedge CLK);
            cycles++;
            if (ack)
            begin
                seen = 1'b1;
                got  = rsp;   // valid with ack
            end
        end
    endtask

    task automatic wait_scl_low(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < ACK_TIMEOUT)
        begin
            @(negedge CLK);
            cycles++;
            seen = !scl;
        end
    endtask

    task automatic run_test(input logic [NAME_W-1:0] name, input logic [7:0] op_c,
                            input logic [`EEPROM_ADDR_W-1:0] a,
                            input logic [`EEPROM_DATA_W-1:0] d, input logic ack_en,
                            input logic [`EEPROM_DATA_W-1:0] exp_data, input logic exp_nack);
        logic                    seen;
        logic                    busy_seen;
        eeprom_pkg::eeprom_rsp_t got;
        int                      acks_before;
        test_errors = 0;
        acks_before = ack_total;
        @(negedge CLK);
        ack_enable = ack_en;
        if (op_c == "R")
            drive_strobe(1'b0, a, 8'($urandom));   // wr_data must not matter
        else
            drive_strobe(1'b1, a, d);
        if (op_c == "B")
        begin
            wait_scl_low(busy_seen);
            if (!busy_seen)
            begin
                $display("%0s: SCL never went low after the request", name);
                test_errors++;
            end
            drive_strobe(1'b1, ~a, ~d);   // lands mid transaction
        end
        wait_ack(seen, got);
        if (!seen)
        begin
            $display("%0s: no ack within %0d cycles", name, ACK_TIMEOUT);
            test_errors++;
        end
        else
        begin
            check_nack(name, exp_nack, got);
            if (op_c == "R" && !exp_nack)
                check_rsp_data(name, exp_data, got.data);
        end
        repeat (20) @(negedge CLK);
        if (ack_total != acks_before + 1)
        begin
            $display("%0s: saw %0d ack pulses where one was due", name, ack_total - acks_before);
            test_errors++;
        end
        report_test(name);
    endtask

    initial
    begin
        int                        fd;
        int                        n;
        string                     line;
        logic [NAME_W-1:0]         name;
        logic [7:0]                op_c;
        logic [`EEPROM_ADDR_W-1:0] a;
        logic [`EEPROM_DATA_W-1:0] d;
        logic [`EEPROM_DATA_W-1:0] exp_data;
        int                        ack_en;
        int                        exp_nack;
        CLK        = 1'b0;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wr_data    = '0;
        ack_enable = 1'b1;
        void'($urandom(32'h5c43_75f5));
        repeat (2) @(negedge CLK);
        RESET = 1'b0;

        // idle bus before any strobe
        test_errors = 0;
        repeat (2) @(negedge CLK);
        check_line("reset_state", "scl", 1'b1, scl);
        check_line("reset_state", "sda_oe", 1'b0, sda_oe);
        check_line("reset_state", "ack", 1'b0, ack);
        report_test("reset_state");

        fd = $fopen("dv/eeprom_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file dv/eeprom_stimulus.txt");
            fail_count++;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 0 && line[0] != "#")
                begin
                    n = $sscanf(line, "%s %s %h %h %d %h %d", name, op_c, a, d, ack_en,
                                exp_data, exp_nack);
                    if (n == 7)
                        run_test(name, op_c, a, d, ack_en[0], exp_data, exp_nack[0]);
                end
            end
            $fclose(fd);
        end

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 1)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* dv/eeprom_slave_model.sv */
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_slave_model
(
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    input  logic ack_enable,
    output logic sda_pull    // high pulls SDA low
);

    localparam int DEPTH = 1 << `EEPROM_ADDR_W;

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } mode_e;

    logic [`EEPROM_DATA_W-1:0] mem [DEPTH];
    mode_e                     mode = M_IDLE;
    logic                      scl_q = 1'b1;
    logic                      sda_q = 1'b1;
    logic [3:0]                bit_cnt = '0;    // SCL rises in the current byte
    logic [`EEPROM_DATA_W-1:0] shreg = '0;
    logic [`EEPROM_DATA_W-1:0] rd_byte = '0;
    logic [2:0]                blk = '0;
    logic [`EEPROM_ADDR_W-1:0] word_addr = '0;
    logic                      rnw = 1'b0;
    logic                      acked = 1'b0;
    logic                      pull_q = 1'b0;

    assign sda_pull = pull_q;

    initial
    begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = 8'(i ^ (i >> 3));
    end

    // oversampled bus, edges seen one CLK late
    always @(posedge CLK)
    begin
        if (scl && scl_q && sda_q && !sda)
        begin
            mode    = M_CTRL;   // start or repeated start
            bit_cnt = '0;
            pull_q <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            mode    = M_IDLE;
            pull_q <= 1'b0;
        end
        else if (mode != M_IDLE && scl && !scl_q)
        begin
            shreg   = {shreg[`EEPROM_DATA_W-2:0], sda};
            bit_cnt = bit_cnt + 4'd1;
        end
        else if (mode != M_IDLE && !scl && scl_q)
        begin
            if (bit_cnt == 4'd8 && mode == M_RDATA)
                pull_q <= 1'b0;   // master owns the ack bit
            else if (bit_cnt == 4'd8)
            begin
                acked = ack_enable;
                case (mode)
                    M_CTRL:
                    begin
                        acked = ack_enable && (shreg[7:4] == `EEPROM_DEV_CODE);
                        blk   = shreg[3:1];
                        rnw   = shreg[0];
                    end
                    M_ADDR:  word_addr = {blk, shreg};
                    default: if (acked) mem[word_addr] = shreg;
                endcase
                pull_q <= acked;
            end
            else if (bit_cnt == 4'd9)
            begin
                pull_q <= 1'b0;
                bit_cnt = '0;
                if (!acked || mode == M_RDATA)
                    mode = M_IDLE;
                else if (mode == M_CTRL && rnw)
                begin
                    // random read, word address left by the dummy write
                    mode      = M_RDATA;
                    word_addr = {blk, word_addr[7:0]};
                    rd_byte   = mem[word_addr];
                    pull_q   <= ~rd_byte[7];
                end
                else if (mode == M_CTRL)
                    mode = M_ADDR;
                else
                    mode = M_WDATA;
            end
            else if (mode == M_RDATA)
                pull_q <= ~rd_byte[3'd7 - bit_cnt[2:0]];
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* source/eeprom_ctrl_top.sv */
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_ctrl_top
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [`EEPROM_DATA_W-1:0] wr_data,
    input  logic                      sda_in,
    output logic                      ack,
    output eeprom_pkg::eeprom_rsp_t   rsp,
    output logic                      scl,
    output logic                      sda_oe
);

    eeprom_pkg::i2c_op_t  op;
    logic                 op_strobe;
    logic                 op_done;
    eeprom_pkg::i2c_res_t res;

    // transaction level
    eeprom_sequencer u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .op_done   (op_done),
        .res       (res),
        .op        (op),
        .op_strobe (op_strobe),
        .ack       (ack),
        .rsp       (rsp)
    );

    // bit level, owns SCL and SDA
    i2c_bit_engine u_bit
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .op        (op),
        .op_strobe (op_strobe),
        .sda_in    (sda_in),
        .op_done   (op_done),
        .res       (res),
        .scl       (scl),
        .sda_oe    (sda_oe)
    );

endmodule

/* source/eeprom_sequencer.sv */
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_sequencer
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [`EEPROM_DATA_W-1:0] wr_data,
    input  logic                      op_done,
    input  eeprom_pkg::i2c_res_t      res,
    output eeprom_pkg::i2c_op_t       op,
    output logic                      op_strobe,
    output logic                      ack,
    output eeprom_pkg::eeprom_rsp_t   rsp
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
    } state_e;

    // operation list, a write stops after ST_DATA
    typedef enum logic [2:0] {
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_DATA,
        ST_RSTART,
        ST_CTRL_R,
        ST_READ,
        ST_STOP
    } step_e;

    state_e                    state;
    step_e                     step;
    eeprom_pkg::eeprom_req_t   req;
    logic                      nack_flag;
    logic [`EEPROM_DATA_W-1:0] rd_data;
    logic                      accept;

    assign accept = (state == S_IDLE) && (wr || rd);

    function automatic eeprom_pkg::i2c_op_t build_op(input step_e s,
                                                     input eeprom_pkg::eeprom_req_t r);
        eeprom_pkg::i2c_op_t o;
        o.cmd  = eeprom_pkg::CMD_WRITE;
        o.data = '0;
        o.mack = 1'b0;
        case (s)
            ST_START, ST_RSTART: o.cmd = eeprom_pkg::CMD_START;
            ST_CTRL_W: o.data = {`EEPROM_DEV_CODE, r.addr[`EEPROM_ADDR_W-1:`EEPROM_DATA_W], 1'b0};
            ST_ADDR:   o.data = r.addr[`EEPROM_DATA_W-1:0];
            ST_DATA:   o.data = r.data;
            ST_CTRL_R: o.data = {`EEPROM_DEV_CODE, r.addr[`EEPROM_ADDR_W-1:`EEPROM_DATA_W], 1'b1};
            ST_READ:
            begin
                o.cmd  = eeprom_pkg::CMD_READ;
                o.mack = 1'b1;   // single byte, so NACK it
            end
            default:   o.cmd = eeprom_pkg::CMD_STOP;
        endcase
        return o;
    endfunction

    // step after a byte the slave acknowledged
    function automatic step_e next_byte_step(input step_e s, input logic is_wr);
        case (s)
            ST_CTRL_W: return ST_ADDR;
            ST_ADDR:   return is_wr ? ST_DATA : ST_RSTART;
            ST_CTRL_R: return ST_READ;
            default:   return ST_STOP;
        endcase
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            step      <= ST_START;
            op_strobe <= 1'b0;
            ack       <= 1'b0;
            nack_flag <= 1'b0;
        end
        else
        begin
            op_strobe <= 1'b0;
            ack       <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (accept)
                    begin
                        nack_flag <= 1'b0;
                        step      <= ST_START;
                        state     <= S_ISSUE;
                    end
                end
                S_ISSUE:
                begin
                    op_strobe <= 1'b1;   // op is loaded in the same cycle
                    state     <= S_WAIT;
                end
                S_WAIT:
                begin
                    if (op_done)
                    begin
                        state <= S_ISSUE;
                        case (step)
                            ST_START:  step <= ST_CTRL_W;
                            ST_RSTART: step <= ST_CTRL_R;
                            ST_READ:   step <= ST_STOP;
                            ST_STOP:
                            begin
                                ack   <= 1'b1;
                                state <= S_IDLE;
                            end
                            default:
                            begin
                                if (res.ack_bit)
                                begin
                                    // slave refused, abort to stop
                                    nack_flag <= 1'b1;
                                    step      <= ST_STOP;
                                end
                                else
                                    step <= next_byte_step(step, req.wr);
                            end
                        endcase
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req     <= '{wr: wr, addr: addr, data: wr_data};   // wr wins over rd
            rd_data <= '0;
        end
        if (state == S_ISSUE)
            op <= build_op(step, req);
        if (state == S_WAIT && op_done && step == ST_READ)
            rd_data <= res.data;
        if (state == S_WAIT && op_done && step == ST_STOP)
            rsp <= '{data: rd_data, nack: nack_flag};
    end

endmodule

/* source/i2c_bit_engine.sv */
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module i2c_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::i2c_op_t  op,
    input  logic                 op_strobe,
    input  logic                 sda_in,
    output logic                 op_done,
    output eeprom_pkg::i2c_res_t res,
    output logic                 scl,
    output logic                 sda_oe
);

    localparam int HALF = `EEPROM_SCL_HALF;
    localparam int CNT_W = $clog2(HALF);
    localparam logic [4:0] LAST_BYTE = 5'd17;   // 9 clocks, low and high each
    localparam logic [4:0] LAST_COND = 5'd2;    // low, high, high

    eeprom_pkg::i2c_cmd_e      cmd;
    logic                      busy;
    logic [CNT_W-1:0]          half_cnt;        // cycles inside the half period
    logic [4:0]                half_idx;        // half periods inside the operation
    logic [3:0]                bit_cnt;
    logic [`EEPROM_DATA_W-1:0] shreg;
    logic                      mack;
    logic                      is_cond;
    logic                      half_end;
    logic                      last_half;
    logic                      low_first;
    logic [4:0]                last_idx;
    logic                      low_sda;

    assign bit_cnt   = half_idx[4:1];           // each bit is a low/high pair
    assign is_cond   = (cmd == eeprom_pkg::CMD_START) || (cmd == eeprom_pkg::CMD_STOP);
    assign last_idx  = is_cond ? LAST_COND : LAST_BYTE;
    assign half_end  = (half_cnt == CNT_W'(HALF - 1));
    assign last_half = (half_idx == last_idx);
    assign low_first = !scl && (half_cnt == '0);

    // SDA pull-low wanted during the current low phase
    always_comb
    begin
        case (cmd)
            eeprom_pkg::CMD_START: low_sda = 1'b0;   // release before a repeated start
            eeprom_pkg::CMD_STOP:  low_sda = 1'b1;
            eeprom_pkg::CMD_WRITE: low_sda = (bit_cnt == 4'd8) ? 1'b0 : ~shreg[`EEPROM_DATA_W-1];
            default:               low_sda = (bit_cnt == 4'd8) ? ~mack : 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy     <= 1'b0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
            op_done  <= 1'b0;
            half_cnt <= '0;
            half_idx <= '0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!busy)
            begin
                if (op_strobe)
                begin
                    busy     <= 1'b1;
                    scl      <= 1'b0;   // every operation opens with SCL low
                    half_cnt <= '0;
                    half_idx <= '0;
                end
            end
            else if (half_end)
            begin
                half_cnt <= '0;
                if (last_half)
                begin
                    busy    <= 1'b0;
                    op_done <= 1'b1;
                end
                else
                begin
                    half_idx <= half_idx + 5'd1;
                    scl      <= is_cond ? 1'b1 : ~scl;
                    // start and stop conditions, SCL already high here
                    if (is_cond && half_idx == 5'd1)
                        sda_oe <= (cmd == eeprom_pkg::CMD_START);
                end
            end
            else
            begin
                half_cnt <= half_cnt + 1'b1;
                if (low_first)
                    sda_oe <= low_sda;   // one cycle after SCL fell
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && op_strobe)
        begin
            cmd   <= op.cmd;
            shreg <= op.data;
            mack  <= op.mack;
        end
        else if (busy)
        begin
            // msb out on SCL low
            if (cmd == eeprom_pkg::CMD_WRITE && low_first && bit_cnt < 4'd8)
                shreg <= {shreg[`EEPROM_DATA_W-2:0], 1'b0};
            // sample at the end of the high phase
            if (cmd == eeprom_pkg::CMD_READ && scl && half_end && bit_cnt < 4'd8)
                shreg <= {shreg[`EEPROM_DATA_W-2:0], sda_in};
            if (half_end && last_half)
                res <= '{data: shreg, ack_bit: sda_in};
        end
    end

endmodule

/* source/eeprom_pkg.sv */
`include "eeprom_consts.svh"

package eeprom_pkg;

    // user request as captured by the sequencer
    typedef struct packed {
        logic                      wr;     // 1 write, 0 random read
        logic [`EEPROM_ADDR_W-1:0] addr;
        logic [`EEPROM_DATA_W-1:0] data;
    } eeprom_req_t;

    // result handed back with ack
    typedef struct packed {
        logic [`EEPROM_DATA_W-1:0] data;
        logic                      nack;   // slave refused a byte
    } eeprom_rsp_t;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } i2c_cmd_e;

    // one bit-engine operation
    typedef struct packed {
        i2c_cmd_e                  cmd;
        logic [`EEPROM_DATA_W-1:0] data;   // byte to send on CMD_WRITE
        logic                      mack;   // master ack bit after CMD_READ, 1 = NACK
    } i2c_op_t;

    typedef struct packed {
        logic [`EEPROM_DATA_W-1:0] data;   // byte received on CMD_READ
        logic                      ack_bit; // SDA on the 9th clock, 1 = no ack
    } i2c_res_t;

endpackage

/* source/eeprom_consts.svh */
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// 2K x 8 array, so 11 address bits
`define EEPROM_ADDR_W 11
`define EEPROM_DATA_W 8

// fixed device code, top nibble of every control byte
`define EEPROM_DEV_CODE 4'b1010

// CLK cycles per SCL half period
// any value of 2 or more works, the engine moves SDA one cycle after SCL falls
`define EEPROM_SCL_HALF 4

`endif
